//--- common/lc3b_types_pkg.sv
package lc3b_types_pkg;

	// processor data word, also used for byte addresses
	typedef logic [15:0] lc3b_word;

	typedef logic [7:0] lc3b_byte;

	// one enable bit per byte of a word, bit 0 is the low byte
	typedef logic [1:0] lc3b_mem_wmask;

endpackage : lc3b_types_pkg

//--- common/cache_pkg.sv
package cache_pkg;

	import lc3b_types_pkg::*;

	// bytes per cache line and per physical transfer
	localparam int block_bytes = 16;

	// byte offset within a block
	localparam int offset_bits = $clog2(block_bytes);

	// words view for reads, bytes view for masked writes
	typedef union packed {
		lc3b_word [block_bytes/2-1:0] words;
		lc3b_byte [block_bytes-1:0] bytes;
	} lc3b_c_block;

endpackage : cache_pkg

//--- cache/cache_control.sv
`timescale 1ns/1ps

module cache_control (
	input  logic clk,
	input  logic rst_n,

	input  logic read,
	input  logic write,
	input  logic hit,
	input  logic dirty,
	output logic resp,

	output logic load_line,
	output logic write_word,
	output logic set_clean,

	output logic pmem_read,
	output logic pmem_write,
	input  logic pmem_resp,
	output logic use_victim
);

	localparam logic [1:0] s_compare    = 2'd0;
	localparam logic [1:0] s_write_back = 2'd1;
	localparam logic [1:0] s_fill       = 2'd2;
	localparam logic [1:0] s_respond    = 2'd3;

	logic [1:0] state;
	logic [1:0] state_next;
	logic       req;

	assign req = read || write;

	always_comb begin
		state_next = state;
		case (state)
			s_compare: begin
				if (req && hit)
					state_next = s_respond;
				else if (req && dirty)
					state_next = s_write_back;
				else if (req)
					state_next = s_fill;
			end
			s_write_back: if (pmem_resp) state_next = s_fill;
			// refilled line is looked up again as a hit
			s_fill:       if (pmem_resp) state_next = s_compare;
			default:      state_next = s_compare;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= s_compare;
		else
			state <= state_next;
	end

	assign resp       = (state == s_respond);
	assign write_word = (state == s_compare) && write && hit;
	assign pmem_write = (state == s_write_back);
	assign pmem_read  = (state == s_fill);
	assign use_victim = (state == s_write_back);
	assign set_clean  = (state == s_write_back) && pmem_resp;
	assign load_line  = (state == s_fill) && pmem_resp;

	a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write));

	// requester has to hold its request until resp
	a_resp_pending: assert property (@(posedge clk) disable iff (!rst_n)
		resp |-> req);

endmodule : cache_control

//--- cache/cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath
	import lc3b_types_pkg::*;
	import cache_pkg::*;
#(
	parameter int num_sets = 8
) (
	input  logic          clk,
	input  logic          rst_n,

	input  lc3b_word      address,
	input  lc3b_mem_wmask byte_enable,
	input  lc3b_word      wdata,
	output lc3b_word      rdata,

	output logic          hit,
	output logic          dirty,
	input  logic          load_line,
	input  logic          write_word,
	input  logic          set_clean,

	input  lc3b_c_block   fill_data,
	output lc3b_c_block   line_data,
	output lc3b_word      victim_address
);

	localparam int index_bits = $clog2(num_sets);
	localparam int tag_bits   = 16 - offset_bits - index_bits;

	logic [tag_bits-1:0]    tag_arr [num_sets];
	lc3b_c_block            data_arr [num_sets];
	logic [num_sets-1:0]    valid_arr;
	logic [num_sets-1:0]    dirty_arr;

	logic [tag_bits-1:0]    tag;
	logic [index_bits-1:0]  index;
	logic [offset_bits-2:0] word_sel;
	lc3b_c_block            merged;

	assign tag      = address[15 -: tag_bits];
	assign index    = address[offset_bits +: index_bits];
	assign word_sel = address[offset_bits-1:1];

	assign line_data = data_arr[index];
	assign rdata     = line_data.words[word_sel];
	assign hit       = valid_arr[index] && (tag_arr[index] == tag);
	assign dirty     = dirty_arr[index];

	// write-back goes to the block the stored tag names
	assign victim_address = {tag_arr[index], index, {offset_bits{1'b0}}};

	// low byte of wdata lands on the even byte of the word
	always_comb begin
		merged = line_data;
		for (int i = 0; i < 2; i++) begin
			if (byte_enable[i])
				merged.bytes[2*word_sel + i] = wdata[8*i +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (load_line) begin
			data_arr[index] <= fill_data;
			tag_arr[index]  <= tag;
		end else if (write_word) begin
			data_arr[index] <= merged;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_arr <= '0;
			dirty_arr <= '0;
		end else if (load_line) begin
			valid_arr[index] <= 1'b1;
			dirty_arr[index] <= 1'b0;
		end else if (write_word) begin
			dirty_arr[index] <= 1'b1;
		end else if (set_clean) begin
			dirty_arr[index] <= 1'b0;
		end
	end

endmodule : cache_datapath

//--- cache/cache.sv
`timescale 1ns/1ps

module cache
	import lc3b_types_pkg::*;
	import cache_pkg::*;
#(
	parameter int num_sets = 8
) (
	input  logic          clk,
	input  logic          rst_n,

	input  logic          read,
	input  logic          write,
	input  lc3b_word      address,
	input  lc3b_mem_wmask byte_enable,
	input  lc3b_word      wdata,
	output lc3b_word      rdata,
	output logic          resp,

	output logic          pmem_read,
	output logic          pmem_write,
	output lc3b_word      pmem_address,
	output lc3b_c_block   pmem_wdata,
	input  lc3b_c_block   pmem_rdata,
	input  logic          pmem_resp
);

	logic     hit;
	logic     dirty;
	logic     load_line;
	logic     write_word;
	logic     set_clean;
	logic     use_victim;
	lc3b_word victim_address;

	// victim block during write-back, else the requested block
	assign pmem_address = use_victim ? victim_address
		: {address[15:offset_bits], {offset_bits{1'b0}}};

	cache_control control (
		.clk, .rst_n,
		.read, .write, .hit, .dirty, .resp,
		.load_line, .write_word, .set_clean,
		.pmem_read, .pmem_write, .pmem_resp, .use_victim
	);

	cache_datapath #(.num_sets(num_sets)) datapath (
		.clk, .rst_n,
		.address, .byte_enable, .wdata, .rdata,
		.hit, .dirty, .load_line, .write_word, .set_clean,
		.fill_data(pmem_rdata),
		.line_data(pmem_wdata),
		.victim_address
	);

endmodule : cache

//--- rtl/arbiter.sv
`timescale 1ns/1ps

module arbiter
	import lc3b_types_pkg::*;
	import cache_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        inst_pmem_read,
	input  logic        inst_pmem_write,
	input  lc3b_word    inst_pmem_address,
	input  lc3b_c_block inst_pmem_wdata,
	output logic        inst_pmem_resp,

	input  logic        data_pmem_read,
	input  logic        data_pmem_write,
	input  lc3b_word    data_pmem_address,
	input  lc3b_c_block data_pmem_wdata,
	output logic        data_pmem_resp,

	output logic        pmem_read,
	output logic        pmem_write,
	output lc3b_word    pmem_address,
	output lc3b_c_block pmem_wdata,
	input  logic        pmem_resp
);

	// bit 1 data cache, bit 0 instruction cache
	logic [1:0] grant;
	logic       inst_req;
	logic       data_req;

	assign inst_req = inst_pmem_read || inst_pmem_write;
	assign data_req = data_pmem_read || data_pmem_write;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= 2'b00;
		end else if (grant == 2'b00) begin
			// data side wins a tie
			if (data_req)
				grant <= 2'b10;
			else if (inst_req)
				grant <= 2'b01;
		end else if (pmem_resp) begin
			grant <= 2'b00;
		end
	end

	assign pmem_read    = (grant[1] && data_pmem_read) || (grant[0] && inst_pmem_read);
	assign pmem_write   = (grant[1] && data_pmem_write) || (grant[0] && inst_pmem_write);
	assign pmem_address = grant[1] ? data_pmem_address : inst_pmem_address;
	assign pmem_wdata   = grant[1] ? data_pmem_wdata : inst_pmem_wdata;

	assign inst_pmem_resp = grant[0] && pmem_resp;
	assign data_pmem_resp = grant[1] && pmem_resp;

	// a grant only stays with a cache that still requests
	a_grant_requested: assert property (@(posedge clk) disable iff (!rst_n)
		(!grant[1] || data_req) && (!grant[0] || inst_req));

	// shared port request holds until memory answers
	a_port_held: assert property (@(posedge clk) disable iff (!rst_n)
		((pmem_read || pmem_write) && !pmem_resp)
		|=> $stable({pmem_read, pmem_write, pmem_address}));

endmodule : arbiter

//--- rtl/lc3b_mem.sv
`timescale 1ns/1ps

module lc3b_mem
	import lc3b_types_pkg::*;
	import cache_pkg::*;
#(
	parameter int num_sets = 8
) (
	input  logic          clk,
	input  logic          rst_n,

	input  logic          inst_read,
	input  logic          inst_write,
	input  lc3b_word      inst_address,
	input  lc3b_mem_wmask inst_byte_enable,
	input  lc3b_word      inst_wdata,
	output lc3b_word      inst_rdata,
	output logic          inst_resp,

	input  logic          data_read,
	input  logic          data_write,
	input  lc3b_word      data_address,
	input  lc3b_mem_wmask data_byte_enable,
	input  lc3b_word      data_wdata,
	output lc3b_word      data_rdata,
	output logic          data_resp,

	output logic          pmem_read,
	output logic          pmem_write,
	output lc3b_word      pmem_address,
	output lc3b_c_block   pmem_wdata,
	input  lc3b_c_block   pmem_rdata,
	input  logic          pmem_resp
);

	logic        inst_pmem_read;
	logic        inst_pmem_write;
	lc3b_word    inst_pmem_address;
	lc3b_c_block inst_pmem_wdata;
	logic        inst_pmem_resp;

	logic        data_pmem_read;
	logic        data_pmem_write;
	lc3b_word    data_pmem_address;
	lc3b_c_block data_pmem_wdata;
	logic        data_pmem_resp;

	cache #(.num_sets(num_sets)) inst_cache (
		.clk, .rst_n,
		.read(inst_read), .write(inst_write), .address(inst_address),
		.byte_enable(inst_byte_enable), .wdata(inst_wdata),
		.rdata(inst_rdata), .resp(inst_resp),
		.pmem_read(inst_pmem_read), .pmem_write(inst_pmem_write),
		.pmem_address(inst_pmem_address), .pmem_wdata(inst_pmem_wdata),
		.pmem_rdata, .pmem_resp(inst_pmem_resp)
	);

	cache #(.num_sets(num_sets)) data_cache (
		.clk, .rst_n,
		.read(data_read), .write(data_write), .address(data_address),
		.byte_enable(data_byte_enable), .wdata(data_wdata),
		.rdata(data_rdata), .resp(data_resp),
		.pmem_read(data_pmem_read), .pmem_write(data_pmem_write),
		.pmem_address(data_pmem_address), .pmem_wdata(data_pmem_wdata),
		.pmem_rdata, .pmem_resp(data_pmem_resp)
	);

	// rdata fans out to both caches, only the granted one samples it
	arbiter mem_arbiter (
		.clk, .rst_n,
		.inst_pmem_read, .inst_pmem_write, .inst_pmem_address,
		.inst_pmem_wdata, .inst_pmem_resp,
		.data_pmem_read, .data_pmem_write, .data_pmem_address,
		.data_pmem_wdata, .data_pmem_resp,
		.pmem_read, .pmem_write, .pmem_address, .pmem_wdata, .pmem_resp
	);

endmodule : lc3b_mem

//--- dv/tb_lc3b_mem.sv
`timescale 1ns/1ps

module tb_lc3b_mem;

	import lc3b_types_pkg::*;
	import cache_pkg::*;

	localparam int resp_timeout = 200;

	logic          clk;
	logic          rst_n;
	logic          inst_read;
	logic          inst_write;
	lc3b_word      inst_address;
	lc3b_mem_wmask inst_byte_enable;
	lc3b_word      inst_wdata;
	lc3b_word      inst_rdata;
	logic          inst_resp;
	logic          data_read;
	logic          data_write;
	lc3b_word      data_address;
	lc3b_mem_wmask data_byte_enable;
	lc3b_word      data_wdata;
	lc3b_word      data_rdata;
	logic          data_resp;
	logic          pmem_read;
	logic          pmem_write;
	lc3b_word      pmem_address;
	lc3b_c_block   pmem_wdata;
	lc3b_c_block   pmem_rdata;
	logic          pmem_resp;

	// physical memory per block and the flat byte view the caches should show
	logic [127:0] phys_mem [4096];
	lc3b_byte     mem_bytes [65536];
	// expected tag of each cache line per port (0 inst, 1 data)
	logic         mvalid [2][8];
	logic [8:0]   mtag [2][8];
	lc3b_word     req_log [$];

	lc3b_mem #(.num_sets(8)) i_lc3b_mem (.*);

	always #10 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check(input logic [127:0] got, input logic [127:0] exp,
			input string what);
		if (got !== exp)
			fail_run($sformatf("Error at %0t: %s, got %0h, expected %0h",
				$time, what, got, exp));
	endtask

	function automatic lc3b_word expected_word(input lc3b_word addr);
		return {mem_bytes[{addr[15:1], 1'b1}], mem_bytes[{addr[15:1], 1'b0}]};
	endfunction

	function automatic logic [127:0] block_from_bytes(input lc3b_word addr);
		logic [127:0] blk;
		for (int k = 0; k < 16; k++)
			blk[8*k +: 8] = mem_bytes[{addr[15:4], 4'(k)}];
		return blk;
	endfunction

	// a few tags over all eight sets so lines conflict often
	function automatic lc3b_word rand_addr(input int port);
		return {port[0], 6'd0, 2'($urandom_range(0, 3)), 3'($urandom_range(0, 7)),
			4'($urandom_range(0, 15))};
	endfunction

	task automatic drive_port(input int port, input logic rd, input logic wr,
			input lc3b_word addr, input lc3b_mem_wmask be, input lc3b_word wd);
		if (port == 0) begin
			inst_read        <= rd;
			inst_write       <= wr;
			inst_address     <= addr;
			inst_byte_enable <= be;
			inst_wdata       <= wd;
		end else begin
			data_read        <= rd;
			data_write       <= wr;
			data_address     <= addr;
			data_byte_enable <= be;
			data_wdata       <= wd;
		end
	endtask

	task automatic access(input int port, input logic wr, input lc3b_word addr,
			input lc3b_mem_wmask be, input lc3b_word wd);
		logic     resident;
		logic     done;
		lc3b_word rd;
		int       cycles;
		resident = mvalid[port][addr[6:4]] && (mtag[port][addr[6:4]] == addr[15:7]);
		done = 1'b0;
		cycles = 0;
		@(posedge clk);
		drive_port(port, !wr, wr, addr, be, wd);
		while (!done) begin
			@(posedge clk);
			cycles++;
			done = port ? data_resp : inst_resp;
			rd = port ? data_rdata : inst_rdata;
			if (!done && cycles >= resp_timeout)
				fail_run($sformatf("timeout, port %0d gave no resp within %0d cycles",
					port, resp_timeout));
		end
		drive_port(port, 1'b0, 1'b0, addr, 2'b00, 16'h0000);
		// hit answers one cycle after the request is first sampled
		check(cycles == 2, resident, "hit latency");
		if (wr) begin
			if (be[0])
				mem_bytes[{addr[15:1], 1'b0}] = wd[7:0];
			if (be[1])
				mem_bytes[{addr[15:1], 1'b1}] = wd[15:8];
		end else begin
			check(rd, expected_word(addr), $sformatf("read data at %h", addr));
		end
		mvalid[port][addr[6:4]] = 1'b1;
		mtag[port][addr[6:4]] = addr[15:7];
	endtask

	task automatic random_traffic(input int port, input int count);
		for (int n = 0; n < count; n++)
			access(port, 1'($urandom_range(0, 1)), rand_addr(port), 2'($urandom_range(0, 3)),
				16'($urandom));
	endtask

	task automatic paired_miss(input lc3b_word inst_addr, input lc3b_word data_addr);
		req_log.delete();
		fork
			access(0, 1'b0, inst_addr, 2'b00, 16'h0000);
			access(1, 1'b0, data_addr, 2'b00, 16'h0000);
		join
		check(req_log.size() >= 2, 1'b1, "both caches reached memory");
		check(req_log[0][15], 1'b1, "data cache served first");
	endtask

	task automatic serve_request();
		logic         wr;
		lc3b_word     addr;
		logic [127:0] wd;
		int           delay;
		wr = pmem_write;
		addr = pmem_address;
		wd = pmem_wdata;
		delay = $urandom_range(1, 5);
		req_log.push_back(addr);
		for (int i = 0; i < delay; i++) begin
			@(posedge clk);
			check(pmem_write, wr, "pmem_write held while pending");
			check(pmem_read, !wr, "pmem_read held while pending");
			check(pmem_address, addr, "pmem_address held while pending");
			check(pmem_wdata, wd, "pmem_wdata held while pending");
		end
		if (wr)
			phys_mem[addr[15:4]] = wd;
		else
			pmem_rdata <= phys_mem[addr[15:4]];
		pmem_resp <= 1'b1;
		@(posedge clk);
		pmem_resp <= 1'b0;
	endtask

	// physical memory model
	always begin
		@(posedge clk);
		check(pmem_read && pmem_write, 1'b0, "one pmem request at a time");
		if (rst_n && (pmem_read || pmem_write))
			serve_request();
	end

	initial begin
		lc3b_word a;
		void'($urandom(14450));
		clk = 1'b0;
		rst_n <= 1'b0;
		pmem_resp <= 1'b0;
		pmem_rdata <= '0;
		drive_port(0, 1'b0, 1'b0, 16'h0000, 2'b00, 16'h0000);
		drive_port(1, 1'b0, 1'b0, 16'h0000, 2'b00, 16'h0000);
		for (int b = 0; b < 4096; b++) begin
			phys_mem[b] = {$urandom, $urandom, $urandom, $urandom};
			for (int k = 0; k < 16; k++)
				mem_bytes[16*b + k] = phys_mem[b][8*k +: 8];
		end
		for (int s = 0; s < 8; s++) begin
			mvalid[0][s] = 1'b0;
			mvalid[1][s] = 1'b0;
		end
		for (int i = 0; i < 18; i++) begin
			@(posedge clk);
			check({inst_resp, data_resp, pmem_read, pmem_write}, 4'b0000, "quiet around reset");
			if (i == 15)
				rst_n <= 1'b1;
		end
		// first reads on both ports miss together
		paired_miss(rand_addr(0), rand_addr(1));
		// masked write, read back, then evict it through a conflicting tag
		for (int n = 0; n < 8; n++) begin
			a = rand_addr(1);
			access(1, 1'b1, a, 2'($urandom_range(0, 3)), 16'($urandom));
			access(1, 1'b0, a, 2'b00, 16'h0000);
			access(1, 1'b0, a ^ 16'h0080, 2'b00, 16'h0000);
			check(phys_mem[a[15:4]], block_from_bytes(a), "written back block");
			access(1, 1'b0, a, 2'b00, 16'h0000);
		end
		fork
			random_traffic(0, 150);
			random_traffic(1, 150);
		join
		// fresh tags so victims may be dirty
		paired_miss(16'h0200 | 16'($urandom_range(0, 127)),
			16'h8200 | 16'($urandom_range(0, 127)));
		$display("Done: no errors");
		$finish;
	end

endmodule : tb_lc3b_mem

//--- lc3b_mem.f
common/lc3b_types_pkg.sv
common/cache_pkg.sv
cache/cache_control.sv
cache/cache_datapath.sv
cache/cache.sv
rtl/arbiter.sv
rtl/lc3b_mem.sv
dv/tb_lc3b_mem.sv

//--- Bender.yml
package:
  name: lc3b_mem

sources:
  # shared packages
  - files:
      - common/lc3b_types_pkg.sv
      - common/cache_pkg.sv

  # caches, arbiter and top level
  - files:
      - cache/cache_control.sv
      - cache/cache_datapath.sv
      - cache/cache.sv
      - rtl/arbiter.sv
      - rtl/lc3b_mem.sv

  # testbench
  - target: test
    files:
      - dv/tb_lc3b_mem.sv
